//--- source/ex_pkg.sv
// execute unit shared definitions
`default_nettype none

package ex_pkg;

	localparam int XLEN      = 64;
	localparam int CTRL_W    = 17;
	localparam int SHAMT_W   = 6;	// rv64 shift amount
	localparam int NUM_PORTS = 2;

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [CTRL_W-1:0] alu_ctrl_t;

	// one-hot bit positions in alu_ctrl_t
	localparam int OP_ADD  = 0;
	localparam int OP_SUB  = 1;
	localparam int OP_SLT  = 2;
	localparam int OP_SLTU = 3;
	localparam int OP_AND  = 4;
	localparam int OP_OR   = 5;
	localparam int OP_XOR  = 6;
	localparam int OP_SLL  = 7;
	localparam int OP_SRL  = 8;
	localparam int OP_SRA  = 9;
	localparam int OP_LUI  = 10;
	localparam int OP_MUL  = 11;
	localparam int OP_DIV  = 12;
	localparam int OP_REM  = 13;
	localparam int OP_MULU = 14;
	localparam int OP_DIVU = 15;
	localparam int OP_REMU = 16;

	// slave side of the four-phase handshake
	typedef enum logic [1:0] {
		IDLE,
		WAIT_GNT,
		ACKED
	} port_state_t;

endpackage

`default_nettype wire

//--- source/alu.sv
// 64-bit integer alu
`default_nettype none

module alu (
	input  ex_pkg::alu_ctrl_t alu_control,
	input  ex_pkg::xlen_t     alu_src1,
	input  ex_pkg::xlen_t     alu_src2,
	output ex_pkg::xlen_t     alu_result
);
	import ex_pkg::*;

	logic op_add, op_sub, op_slt, op_sltu;
	logic op_and, op_or, op_xor;
	logic op_sll, op_srl, op_sra, op_lui;
	logic op_mul, op_div, op_rem, op_mulu, op_divu, op_remu;

	assign op_add  = alu_control[OP_ADD];
	assign op_sub  = alu_control[OP_SUB];
	assign op_slt  = alu_control[OP_SLT];
	assign op_sltu = alu_control[OP_SLTU];
	assign op_and  = alu_control[OP_AND];
	assign op_or   = alu_control[OP_OR];
	assign op_xor  = alu_control[OP_XOR];
	assign op_sll  = alu_control[OP_SLL];
	assign op_srl  = alu_control[OP_SRL];
	assign op_sra  = alu_control[OP_SRA];
	assign op_lui  = alu_control[OP_LUI];
	assign op_mul  = alu_control[OP_MUL];
	assign op_div  = alu_control[OP_DIV];
	assign op_rem  = alu_control[OP_REM];
	assign op_mulu = alu_control[OP_MULU];
	assign op_divu = alu_control[OP_DIVU];
	assign op_remu = alu_control[OP_REMU];

	xlen_t add_sub_result;
	xlen_t slt_result;
	xlen_t sltu_result;
	xlen_t and_result;
	xlen_t or_result;
	xlen_t xor_result;
	xlen_t sll_result;
	xlen_t srl_result;
	xlen_t sra_result;
	xlen_t lui_result;
	xlen_t mul_result;
	xlen_t div_result;
	xlen_t rem_result;
	xlen_t mulu_result;
	xlen_t divu_result;
	xlen_t remu_result;

	assign and_result = alu_src1 & alu_src2;
	assign or_result  = alu_src1 | alu_src2;
	assign xor_result = alu_src1 ^ alu_src2;
	assign lui_result = {{32{alu_src2[31]}}, alu_src2[31:0]};	// sign extend from bit 31

	// shared adder, compares run as subtract
	logic  sub_mode;
	xlen_t adder_b;
	xlen_t adder_result;
	logic  adder_cout;

	assign sub_mode = op_sub | op_slt | op_sltu;
	assign adder_b  = sub_mode ? ~alu_src2 : alu_src2;
	assign {adder_cout, adder_result} = {1'b0, alu_src1} + {1'b0, adder_b}
		+ {{XLEN{1'b0}}, sub_mode};

	assign add_sub_result = adder_result;

	// src1 negative and src2 not, or same sign and difference negative
	assign slt_result[XLEN-1:1] = '0;
	assign slt_result[0] = (alu_src1[63] & ~alu_src2[63])
		| (~(alu_src1[63] ^ alu_src2[63]) & adder_result[63]);

	assign sltu_result[XLEN-1:1] = '0;
	assign sltu_result[0]        = ~adder_cout;	// borrow out

	logic [SHAMT_W-1:0] shamt;

	assign shamt      = alu_src2[SHAMT_W-1:0];
	assign sll_result = alu_src1 << shamt;
	assign srl_result = alu_src1 >> shamt;
	assign sra_result = $signed(alu_src1) >>> shamt;

	// low half only
	assign mulu_result = alu_src1 * alu_src2;
	assign mul_result  = $signed(alu_src1) * $signed(alu_src2);

	logic  div_zero;
	logic  div_ovf;
	xlen_t quot_s;
	xlen_t rem_s;

	assign div_zero = (alu_src2 == '0);
	assign div_ovf  = (alu_src1 == {1'b1, {(XLEN-1){1'b0}}}) & (&alu_src2);	// min / -1

	// signed quotient and remainder
	assign quot_s = $signed(alu_src1) / $signed(alu_src2);
	assign rem_s  = $signed(alu_src1) % $signed(alu_src2);

	assign divu_result = div_zero ? '1 : alu_src1 / alu_src2;
	assign remu_result = div_zero ? alu_src1 : alu_src1 % alu_src2;
	assign div_result  = div_zero ? '1
		: div_ovf ? alu_src1
		: quot_s;
	assign rem_result  = div_zero ? alu_src1
		: div_ovf ? '0
		: rem_s;

	assign alu_result = ({XLEN{op_add | op_sub}} & add_sub_result)
		| ({XLEN{op_slt }} & slt_result)
		| ({XLEN{op_sltu}} & sltu_result)
		| ({XLEN{op_and }} & and_result)
		| ({XLEN{op_or  }} & or_result)
		| ({XLEN{op_xor }} & xor_result)
		| ({XLEN{op_sll }} & sll_result)
		| ({XLEN{op_srl }} & srl_result)
		| ({XLEN{op_sra }} & sra_result)
		| ({XLEN{op_lui }} & lui_result)
		| ({XLEN{op_mul }} & mul_result)
		| ({XLEN{op_div }} & div_result)
		| ({XLEN{op_rem }} & rem_result)
		| ({XLEN{op_mulu}} & mulu_result)
		| ({XLEN{op_divu}} & divu_result)
		| ({XLEN{op_remu}} & remu_result);

endmodule

`default_nettype wire

//--- source/alu_arbiter.sv
// two-port round-robin alu arbiter
`default_nettype none

module alu_arbiter (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire  [ex_pkg::NUM_PORTS-1:0]  bus_req,
	input  ex_pkg::alu_ctrl_t             p0_ctrl,
	input  ex_pkg::xlen_t                 p0_src1,
	input  ex_pkg::xlen_t                 p0_src2,
	input  ex_pkg::alu_ctrl_t             p1_ctrl,
	input  ex_pkg::xlen_t                 p1_src1,
	input  ex_pkg::xlen_t                 p1_src2,
	output logic [ex_pkg::NUM_PORTS-1:0]  gnt,
	output ex_pkg::alu_ctrl_t             alu_control,
	output ex_pkg::xlen_t                 alu_src1,
	output ex_pkg::xlen_t                 alu_src2
);

	logic last_winner;	// 1 means port 1 won last

	// on a tie the port that did not win last goes first
	assign gnt[0] = bus_req[0] & (~bus_req[1] | last_winner);
	assign gnt[1] = bus_req[1] & (~bus_req[0] | ~last_winner);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_winner <= 1'b1;	// port 0 takes the first tie
		end else if (|gnt) begin
			last_winner <= gnt[1];
		end
	end

	// operand steering, zeros when idle
	always_comb begin
		alu_control = '0;
		alu_src1    = '0;
		alu_src2    = '0;
		if (gnt[0]) begin
			alu_control = p0_ctrl;
			alu_src1    = p0_src1;
			alu_src2    = p0_src2;
		end else if (gnt[1]) begin
			alu_control = p1_ctrl;
			alu_src1    = p1_src1;
			alu_src2    = p1_src2;
		end
	end

endmodule

`default_nettype wire

//--- source/alu_port_ctrl.sv
// four-phase port controller
`default_nettype none

module alu_port_ctrl (
	input  wire           clk,
	input  wire           arst_n,
	input  wire           req,
	input  wire           gnt,
	input  ex_pkg::xlen_t alu_result,
	output logic          bus_req,
	output logic          ack,
	output ex_pkg::xlen_t result
);
	import ex_pkg::*;

	port_state_t state;
	port_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_nxt = WAIT_GNT;
				end
			end
			WAIT_GNT: begin
				if (gnt) begin
					state_nxt = ACKED;
				end
			end
			ACKED: begin
				if (!req) begin	// requester saw ack and let go
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// result held stable for the whole ack phase
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else if (state == WAIT_GNT && gnt) begin
			result <= alu_result;
		end
	end

	assign bus_req = (state == WAIT_GNT);
	assign ack     = (state == ACKED);

endmodule

`default_nettype wire

//--- source/ex_unit_top.sv
// shared execute unit top
`default_nettype none

module ex_unit_top (
	input  wire               clk,
	input  wire               arst_n,
	input  wire               p0_req,
	input  ex_pkg::alu_ctrl_t p0_ctrl,
	input  ex_pkg::xlen_t     p0_src1,
	input  ex_pkg::xlen_t     p0_src2,
	output logic              p0_ack,
	output ex_pkg::xlen_t     p0_result,
	input  wire               p1_req,
	input  ex_pkg::alu_ctrl_t p1_ctrl,
	input  ex_pkg::xlen_t     p1_src1,
	input  ex_pkg::xlen_t     p1_src2,
	output logic              p1_ack,
	output ex_pkg::xlen_t     p1_result
);
	import ex_pkg::*;

	logic [NUM_PORTS-1:0] bus_req;
	logic [NUM_PORTS-1:0] gnt;
	alu_ctrl_t            alu_control;
	xlen_t                alu_src1;
	xlen_t                alu_src2;
	xlen_t                alu_result;	// seen by both ports

	alu_port_ctrl port0_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (p0_req),
		.gnt        (gnt[0]),
		.alu_result (alu_result),
		.bus_req    (bus_req[0]),
		.ack        (p0_ack),
		.result     (p0_result)
	);

	alu_port_ctrl port1_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (p1_req),
		.gnt        (gnt[1]),
		.alu_result (alu_result),
		.bus_req    (bus_req[1]),
		.ack        (p1_ack),
		.result     (p1_result)
	);

	// operands come straight from the port inputs
	alu_arbiter arb (
		.clk         (clk),
		.arst_n      (arst_n),
		.bus_req     (bus_req),
		.p0_ctrl     (p0_ctrl),
		.p0_src1     (p0_src1),
		.p0_src2     (p0_src2),
		.p1_ctrl     (p1_ctrl),
		.p1_src1     (p1_src1),
		.p1_src2     (p1_src2),
		.gnt         (gnt),
		.alu_control (alu_control),
		.alu_src1    (alu_src1),
		.alu_src2    (alu_src2)
	);

	alu alu_core (
		.alu_control (alu_control),
		.alu_src1    (alu_src1),
		.alu_src2    (alu_src2),
		.alu_result  (alu_result)
	);

endmodule

`default_nettype wire

//--- dv/ex_unit_tb.sv
// execute unit testbench
`default_nettype none

module ex_unit_tb;
	import ex_pkg::*;

	localparam int    NUM_TXN  = 250;	// all directed and random transactions
	localparam xlen_t MIN_NEG  = 64'h8000_0000_0000_0000;
	localparam xlen_t ALL_ONES = '1;

	logic        clk;
	logic        arst_n;
	logic        p0_req;
	logic        p1_req;
	alu_ctrl_t   p0_ctrl;
	alu_ctrl_t   p1_ctrl;
	xlen_t       p0_src1;
	xlen_t       p0_src2;
	xlen_t       p1_src1;
	xlen_t       p1_src2;
	logic        p0_ack;
	logic        p1_ack;
	xlen_t       p0_result;
	xlen_t       p1_result;
	xlen_t       res0;
	xlen_t       res1;
	logic [31:0] lcg_state;

	ex_unit_top ex_unit_top_inst (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic alu_ctrl_t onehot(int idx);
		alu_ctrl_t c;
		c = '0;
		c[idx] = 1'b1;
		return c;
	endfunction

	// expected result straight from the operation rules
	function automatic xlen_t alu_model(alu_ctrl_t ctrl, xlen_t a, xlen_t b);
		if (ctrl[OP_ADD]) return a + b;
		if (ctrl[OP_SUB]) return a - b;
		if (ctrl[OP_SLT]) return {63'd0, $signed(a) < $signed(b)};
		if (ctrl[OP_SLTU]) return {63'd0, a < b};
		if (ctrl[OP_AND]) return a & b;
		if (ctrl[OP_OR]) return a | b;
		if (ctrl[OP_XOR]) return a ^ b;
		if (ctrl[OP_SLL]) return a << b[5:0];
		if (ctrl[OP_SRL]) return a >> b[5:0];
		if (ctrl[OP_SRA]) return $signed(a) >>> b[5:0];
		if (ctrl[OP_LUI]) return {{32{b[31]}}, b[31:0]};
		if (ctrl[OP_MUL] || ctrl[OP_MULU]) return a * b;
		if (ctrl[OP_DIV]) begin
			if (b == 0) return ALL_ONES;
			if (a == MIN_NEG && b == ALL_ONES) return a;
			return $signed(a) / $signed(b);
		end
		if (ctrl[OP_REM]) begin
			if (b == 0) return a;
			if (a == MIN_NEG && b == ALL_ONES) return 64'd0;
			return $signed(a) % $signed(b);
		end
		if (ctrl[OP_DIVU]) return (b == 0) ? ALL_ONES : a / b;
		if (ctrl[OP_REMU]) return (b == 0) ? a : a % b;
		return '0;
	endfunction

	function automatic logic ack_of(int port);
		return (port == 0) ? p0_ack : p1_ack;
	endfunction

	function automatic xlen_t result_of(int port);
		return (port == 0) ? p0_result : p1_result;
	endfunction

	task automatic fail_now();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(string name, xlen_t got, xlen_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic drive_port(int port, logic req, alu_ctrl_t ctrl, xlen_t a, xlen_t b);
		if (port == 0) begin
			p0_req  = req;
			p0_ctrl = ctrl;
			p0_src1 = a;
			p0_src2 = b;
		end else begin
			p1_req  = req;
			p1_ctrl = ctrl;
			p1_src1 = a;
			p1_src2 = b;
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	endtask

	// one four-phase transaction, exp_lat of 0 skips the latency check
	task automatic run_txn(int port, alu_ctrl_t ctrl, xlen_t a, xlen_t b, int hold,
			int exp_lat, output xlen_t res);
		string pname;
		int    n;
		pname = (port == 0) ? "p0" : "p1";
		@(negedge clk);
		drive_port(port, 1'b1, ctrl, a, b);
		n = 0;
		while (!ack_of(port)) begin
			@(negedge clk);
			n++;
			if (n > 10) begin
				$display("timeout, ack never rose on port %0d", port);
				fail_now();
			end
		end
		if (exp_lat != 0) check_value({pname, "_ack latency"}, xlen_t'(n), xlen_t'(exp_lat));
		res = result_of(port);
		check_value({pname, "_result"}, res, alu_model(ctrl, a, b));
		repeat (hold) begin
			@(negedge clk);
			check_value({pname, "_ack"}, xlen_t'(ack_of(port)), 64'd1);
			check_value({pname, "_result"}, result_of(port), res);
		end
		drive_port(port, 1'b0, ctrl, a, b);
		@(negedge clk);
		check_value({pname, "_ack"}, xlen_t'(ack_of(port)), 64'd0);	// falls on first edge
	endtask

	task automatic op_on_port0(int idx, xlen_t a, xlen_t b);
		run_txn(0, onehot(idx), a, b, 0, 2, res0);
	endtask

	task automatic handshake_basics();
		check_value("p0_ack", xlen_t'(p0_ack), 64'd0);
		check_value("p1_ack", xlen_t'(p1_ack), 64'd0);
		check_value("p0_result", p0_result, 64'd0);
		check_value("p1_result", p1_result, 64'd0);
		repeat (3) begin
			@(negedge clk);
			check_value("p0_ack", xlen_t'(p0_ack), 64'd0);
			check_value("p1_ack", xlen_t'(p1_ack), 64'd0);
		end
		run_txn(0, onehot(OP_ADD), 64'd40, 64'd2, 4, 2, res0);
	endtask

	task automatic every_op();
		op_on_port0(OP_ADD, 64'h7fff_ffff_ffff_ffff, 64'd1);
		op_on_port0(OP_SUB, 64'd3, 64'd5);
		op_on_port0(OP_SLT, ALL_ONES, 64'd1);
		op_on_port0(OP_SLT, 64'd1, ALL_ONES);
		op_on_port0(OP_SLT, MIN_NEG, 64'h7fff_ffff_ffff_ffff);
		op_on_port0(OP_SLTU, ALL_ONES, 64'd1);
		op_on_port0(OP_SLTU, 64'd1, ALL_ONES);
		op_on_port0(OP_AND, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00);
		op_on_port0(OP_OR, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00);
		op_on_port0(OP_XOR, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00);
		op_on_port0(OP_SLL, 64'd1, 64'd40);
		op_on_port0(OP_SRL, 64'hf000_0000_0000_0000, 64'd4);
		op_on_port0(OP_SRA, 64'hf000_0000_0000_0000, 64'd8);
		op_on_port0(OP_LUI, 64'd0, 64'h0000_0000_8000_1000);
		op_on_port0(OP_LUI, 64'd0, 64'hffff_ffff_7abc_d000);
		op_on_port0(OP_MUL, ALL_ONES, 64'd5);
		op_on_port0(OP_DIV, 64'hffff_ffff_ffff_ff9c, 64'd7);
		op_on_port0(OP_REM, 64'hffff_ffff_ffff_ff9c, 64'd7);
		op_on_port0(OP_MULU, 64'h1_0000_0001, 64'h1_0000_0003);
		op_on_port0(OP_DIVU, ALL_ONES, 64'd3);
		op_on_port0(OP_REMU, 64'd1000, 64'd7);
	endtask

	task automatic edge_operands();
		op_on_port0(OP_SLL, 64'h8000_0000_0000_0001, 64'd0);
		op_on_port0(OP_SRL, MIN_NEG, 64'd63);
		op_on_port0(OP_SRA, MIN_NEG, 64'd63);
		op_on_port0(OP_SLL, 64'd3, 64'hffff_ffff_ffff_ff41);	// shamt 1
		op_on_port0(OP_DIV, 64'd77, 64'd0);
		op_on_port0(OP_REM, 64'd77, 64'd0);
		op_on_port0(OP_DIVU, 64'd77, 64'd0);
		op_on_port0(OP_REMU, 64'd77, 64'd0);
		op_on_port0(OP_DIV, MIN_NEG, ALL_ONES);
		op_on_port0(OP_REM, MIN_NEG, ALL_ONES);
		run_txn(0, '0, 64'd12, 64'd34, 0, 2, res0);
	endtask

	task automatic tie_breaking();
		apply_reset();
		fork
			run_txn(0, onehot(OP_ADD), 64'd5, 64'd7, 0, 2, res0);
			run_txn(1, onehot(OP_XOR), 64'hff00, 64'h0ff0, 0, 3, res1);
		join
		// port 1 won last, a lone port 0 turn hands the next tie to port 1
		run_txn(0, onehot(OP_SUB), 64'd1, 64'd2, 0, 2, res0);
		fork
			run_txn(0, onehot(OP_MUL), 64'd9, 64'd9, 0, 3, res0);
			run_txn(1, onehot(OP_SLL), 64'd5, 64'd2, 0, 2, res1);
		join
	endtask

	task automatic back_pressure();
		fork
			run_txn(0, onehot(OP_DIVU), 64'd1000, 64'd7, 30, 2, res0);
			begin
				while (!p0_ack) begin
					@(negedge clk);
				end
				for (int i = 0; i < 4; i++) begin
					run_txn(1, onehot(OP_ADD), xlen_t'(i), 64'd100, 1, 2, res1);
				end
			end
		join
	endtask

	task automatic rand_op(output alu_ctrl_t ctrl, output xlen_t a, output xlen_t b);
		int idx;
		idx  = int'((next_rand() >> 8) % 18);
		ctrl = (idx == 17) ? '0 : onehot(idx);
		a    = {next_rand(), next_rand()};
		b    = {next_rand(), next_rand()};
		case ((next_rand() >> 20) % 8)
			0: b = '0;
			1: b = ALL_ONES;
			2: b = {56'd0, b[7:0]};
			default: ;
		endcase
		if (((next_rand() >> 20) % 8) == 0) a = MIN_NEG;
	endtask

	task automatic random_traffic();
		alu_ctrl_t c0;
		alu_ctrl_t c1;
		xlen_t     a0;
		xlen_t     b0;
		xlen_t     a1;
		xlen_t     b1;
		int        mode;
		int        done_cnt;
		done_cnt = 0;
		while (done_cnt < 200) begin
			mode = int'((next_rand() >> 16) % 3);	// 2 means both ports
			rand_op(c0, a0, b0);
			rand_op(c1, a1, b1);
			if (mode == 2) begin
				fork
					run_txn(0, c0, a0, b0, int'((next_rand() >> 16) % 4), 0, res0);
					run_txn(1, c1, a1, b1, int'((next_rand() >> 12) % 4), 0, res1);
				join
				done_cnt += 2;
			end else begin
				run_txn(mode, c0, a0, b0, int'((next_rand() >> 16) % 4), 0, res0);
				done_cnt++;
			end
		end
	endtask

	initial begin
		#(NUM_TXN * 10 * 40);
		$display("watchdog timeout, the tests did not finish in time");
		fail_now();
	end

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		lcg_state = 32'hb580;
		drive_port(0, 1'b0, '0, '0, '0);
		drive_port(1, 1'b0, '0, '0, '0);
		apply_reset();
		handshake_basics();
		every_op();
		edge_operands();
		tie_breaking();
		back_pressure();
		random_traffic();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
source/ex_pkg.sv
source/alu.sv
source/alu_arbiter.sv
source/alu_port_ctrl.sv
source/ex_unit_top.sv
dv/ex_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ex_unit_tb -f files.f -o ex_unit_sim \
	&& ./obj_dir/ex_unit_sim | tee sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
